/* hdl/pixel_pkg.sv */
// Pixel readout package with host bus, data word and sequence types plus the address map
package pixel_pkg;

    typedef logic [7:0] byte_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [7:0]  wdata;
        logic        rd;
        logic        wr;
    } bus_req_t;

    // id in the top bits
    typedef struct packed {
        logic [3:0]  id;
        logic [11:0] index;
        logic [15:0] payload;
    } word_t;

    // sr_in sits in bit 0, the spare bits on top
    typedef struct packed {
        logic [1:0] spare;
        logic       inject;
        logic       pixel_sr_en;
        logic       global_dac_ld;
        logic       global_ctr_ld;
        logic       global_sr_en;
        logic       sr_in;
    } seq_t;

    // block windows, 16 registers each
    localparam logic [15:0] gpio_base = 16'h0000;
    localparam logic [15:0] spi_rx_base = 16'h0100;
    localparam logic [15:0] tdc_base = 16'h0200;
    localparam logic [15:0] seq_base = 16'h1000;

    // pattern memory sits behind the seq registers
    localparam logic [15:0] seq_mem_offset = 16'h0010;
    localparam int seq_mem_bytes = 256;

    // register offsets inside a window
    localparam logic [3:0] reg_ctrl = 4'h0;
    localparam logic [3:0] reg_lost = 4'h1;
    localparam logic [3:0] reg_len = 4'h1;
    localparam logic [3:0] reg_done = 4'h2;

    localparam logic [3:0] spi_rx_id = 4'b0001;
    localparam logic [3:0] tdc_id = 4'b0100;

    localparam int src_fifo_depth = 16;
    localparam int out_fifo_depth = 32;
    localparam int near_full_level = 28;

endpackage

/* hdl/sync_fifo.sv */
// Show-ahead synchronous FIFO, circular buffer with a fill count and a typed payload
module sync_fifo #(
    parameter type payload_t = pixel_pkg::word_t,
    parameter int depth = 16,
    parameter int near_level = 16
) (
    input  logic     bus_clk,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,
    output payload_t data,
    output logic     empty,
    output logic     full,
    output logic     near_full
);

    payload_t mem [depth];

    // depth is a power of two, pointers wrap on their own
    logic [$clog2(depth)-1:0] wr_ptr;
    logic [$clog2(depth)-1:0] rd_ptr;
    logic [$clog2(depth+1)-1:0] count;
    logic do_push;
    logic do_pop;

    assign do_push = push && !full;
    assign do_pop = pop && !empty;

    assign empty = count == '0;
    assign full = count == $bits(count)'(depth);
    assign near_full = count >= $bits(count)'(near_level);

    // head is visible without a read
    assign data = mem[rd_ptr];

    always_ff @(posedge bus_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: ;
            endcase
        end
    end

endmodule

/* hdl/gpio.sv */
// Output port bank, one bus-writable register driving the board enables and LEDs
module gpio #(
    parameter logic [15:0] base = pixel_pkg::gpio_base
) (
    input  logic                bus_clk,
    input  logic                rst,
    input  pixel_pkg::bus_req_t bus,
    output pixel_pkg::byte_t    rdata,
    output pixel_pkg::byte_t    io
);

    logic reg_hit;

    // only register 0 of the window is populated
    assign reg_hit = (bus.addr[15:4] == base[15:4]) && (bus.addr[3:0] == pixel_pkg::reg_ctrl);

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            io <= '0;
            rdata <= '0;
        end else begin
            if (bus.wr && reg_hit) begin
                io <= bus.wdata;
            end
            if (bus.rd && reg_hit) begin
                rdata <= io;
            end else begin
                rdata <= '0;
            end
        end
    end

endmodule

/* hdl/seq_gen.sv */
// Sequence generator, plays a stored byte pattern onto the chip control lines
module seq_gen (
    input  logic                bus_clk,
    input  logic                rst,
    input  pixel_pkg::bus_req_t bus,
    output pixel_pkg::byte_t    rdata,
    output pixel_pkg::seq_t     seq_out
);

    pixel_pkg::byte_t mem [pixel_pkg::seq_mem_bytes];

    logic [15:0] offset;
    logic [15:0] mem_off;
    logic reg_sel;
    logic mem_sel;
    logic start_wr;
    pixel_pkg::byte_t len;
    logic [7:0] step;
    logic running;
    logic done;

    assign offset = bus.addr - pixel_pkg::seq_base;
    assign mem_off = offset - pixel_pkg::seq_mem_offset;
    assign reg_sel = offset < pixel_pkg::seq_mem_offset;
    // below the memory mem_off wraps high and misses
    assign mem_sel = mem_off < 16'(pixel_pkg::seq_mem_bytes);
    assign start_wr = bus.wr && reg_sel && (offset[3:0] == pixel_pkg::reg_ctrl) && bus.wdata[0];

    always_ff @(posedge bus_clk) begin
        if (bus.wr && mem_sel) begin
            mem[mem_off[7:0]] <= bus.wdata;
        end
    end

    // player, first byte out one cycle after the start write
    always_ff @(posedge bus_clk) begin
        if (rst) begin
            len <= '0;
            step <= '0;
            running <= 1'b0;
            done <= 1'b0;
            seq_out <= '0;
        end else begin
            if (bus.wr && reg_sel && (offset[3:0] == pixel_pkg::reg_len)) begin
                len <= bus.wdata;
            end
            if (start_wr) begin
                running <= 1'b1;
                done <= 1'b0;
                step <= '0;
                seq_out <= '0;
            end else if (running) begin
                seq_out <= pixel_pkg::seq_t'(mem[step]);
                step <= step + 1'b1;
                if (step == len - 8'd1) begin
                    running <= 1'b0;
                    done <= 1'b1;
                end
            end else begin
                seq_out <= '0;
            end
        end
    end

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            rdata <= '0;
        end else if (bus.rd && reg_sel) begin
            case (offset[3:0])
                pixel_pkg::reg_ctrl: rdata <= {7'b0, running};
                pixel_pkg::reg_len: rdata <= len;
                pixel_pkg::reg_done: rdata <= {7'b0, done};
                default: rdata <= '0;
            endcase
        end else if (bus.rd && mem_sel) begin
            rdata <= mem[mem_off[7:0]];
        end else begin
            rdata <= '0;
        end
    end

endmodule

/* hdl/spi_rx.sv */
// Serial receiver, packs pixel shift-register output bits into tagged 32-bit words
module spi_rx (
    input  logic                bus_clk,
    input  logic                rst,
    input  pixel_pkg::bus_req_t bus,
    output pixel_pkg::byte_t    rdata,
    input  logic                sen,
    input  logic                sdi,
    input  logic                pop,
    output logic                empty,
    output pixel_pkg::word_t    data
);

    logic sel;
    logic ctrl_wr;
    logic en;
    logic sample;
    logic [14:0] shift;
    logic [3:0] bit_cnt;
    logic [11:0] index;
    logic push;
    pixel_pkg::word_t push_word;
    logic full;
    pixel_pkg::byte_t lost;

    assign sel = bus.addr[15:4] == pixel_pkg::spi_rx_base[15:4];
    assign ctrl_wr = bus.wr && sel && (bus.addr[3:0] == pixel_pkg::reg_ctrl);
    assign sample = en && sen;

    always_ff @(posedge bus_clk) begin
        if (sample) begin
            shift <= {shift[13:0], sdi};
        end
        // 16th bit completes the word, msb first
        if (sample && bit_cnt == 4'd15) begin
            push_word <= '{id: pixel_pkg::spi_rx_id, index: index, payload: {shift, sdi}};
        end
    end

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            en <= 1'b0;
            bit_cnt <= '0;
            index <= '0;
            push <= 1'b0;
            lost <= '0;
            rdata <= '0;
        end else begin
            push <= 1'b0;
            if (ctrl_wr) begin
                en <= bus.wdata[0];
                bit_cnt <= '0;
                index <= '0;
            end else if (sample) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 4'd15) begin
                    push <= 1'b1;
                    index <= index + 1'b1;
                end
            end else begin
                // partial group dropped when sen falls
                bit_cnt <= '0;
            end
            if (push && full && lost != 8'hff) begin
                lost <= lost + 1'b1;
            end
            if (bus.rd && sel) begin
                case (bus.addr[3:0])
                    pixel_pkg::reg_ctrl: rdata <= {7'b0, en};
                    pixel_pkg::reg_lost: rdata <= lost;
                    default: rdata <= '0;
                endcase
            end else begin
                rdata <= '0;
            end
        end
    end

    sync_fifo #(
        .payload_t (pixel_pkg::word_t),
        .depth     (pixel_pkg::src_fifo_depth),
        .near_level(pixel_pkg::src_fifo_depth)
    ) i_fifo (
        .bus_clk  (bus_clk),
        .rst      (rst),
        .push     (push),
        .push_data(push_word),
        .pop      (pop),
        .data     (data),
        .empty    (empty),
        .full     (full),
        .near_full()
    );

endmodule

/* hdl/tdc.sv */
// Hit timer, measures hit-or pulse lengths in clock cycles and emits tagged words
module tdc (
    input  logic                bus_clk,
    input  logic                rst,
    input  pixel_pkg::bus_req_t bus,
    output pixel_pkg::byte_t    rdata,
    input  logic                hit,
    input  logic                pop,
    output logic                empty,
    output pixel_pkg::word_t    data
);

    logic sel;
    logic ctrl_wr;
    logic en;
    logic hit_q;
    logic hit_d;
    logic [15:0] len;
    logic [11:0] index;
    logic push;
    pixel_pkg::word_t push_word;
    logic full;
    pixel_pkg::byte_t lost;

    assign sel = bus.addr[15:4] == pixel_pkg::tdc_base[15:4];
    assign ctrl_wr = bus.wr && sel && (bus.addr[3:0] == pixel_pkg::reg_ctrl);

    // falling edge of the sampled hit closes the pulse
    assign push = en && hit_d && !hit_q;
    assign push_word = '{id: pixel_pkg::tdc_id, index: index, payload: len};

    always_ff @(posedge bus_clk) begin
        if (hit_q && !hit_d) begin
            len <= 16'd1;
        end else if (hit_q && len != 16'hffff) begin
            len <= len + 1'b1;
        end
    end

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            hit_q <= 1'b0;
            hit_d <= 1'b0;
            en <= 1'b0;
            index <= '0;
            lost <= '0;
            rdata <= '0;
        end else begin
            hit_q <= hit;
            hit_d <= hit_q;
            if (ctrl_wr) begin
                en <= bus.wdata[0];
                index <= '0;
            end else if (push) begin
                index <= index + 1'b1;
            end
            if (push && full && lost != 8'hff) begin
                lost <= lost + 1'b1;
            end
            if (bus.rd && sel) begin
                case (bus.addr[3:0])
                    pixel_pkg::reg_ctrl: rdata <= {7'b0, en};
                    pixel_pkg::reg_lost: rdata <= lost;
                    default: rdata <= '0;
                endcase
            end else begin
                rdata <= '0;
            end
        end
    end

    sync_fifo #(
        .payload_t (pixel_pkg::word_t),
        .depth     (pixel_pkg::src_fifo_depth),
        .near_level(pixel_pkg::src_fifo_depth)
    ) i_fifo (
        .bus_clk  (bus_clk),
        .rst      (rst),
        .push     (push),
        .push_data(push_word),
        .pop      (pop),
        .data     (data),
        .empty    (empty),
        .full     (full),
        .near_full()
    );

endmodule

/* hdl/rr_arbiter.sv */
// Round-robin arbiter merging two word sources into one write stream
module rr_arbiter (
    input  logic                   bus_clk,
    input  logic                   rst,
    input  logic [1:0]             req,
    input  pixel_pkg::word_t [1:0] data_in,
    output logic [1:0]             grant,
    input  logic                   ready,
    output logic                   write,
    output pixel_pkg::word_t       data_out
);

    // index of the source granted last
    logic last;

    always_comb begin
        grant = 2'b00;
        if (ready) begin
            if (last) begin
                if (req[0]) begin
                    grant = 2'b01;
                end else if (req[1]) begin
                    grant = 2'b10;
                end
            end else begin
                if (req[1]) begin
                    grant = 2'b10;
                end else if (req[0]) begin
                    grant = 2'b01;
                end
            end
        end
    end

    assign write = |grant;
    assign data_out = grant[1] ? data_in[1] : data_in[0];

    always_ff @(posedge bus_clk) begin
        if (rst) begin
            last <= 1'b0;
        end else if (write) begin
            last <= grant[1];
        end
    end

endmodule

/* hdl/pixel.sv */
// Pixel detector readout controller, host bus blocks, data merge and board pins
module pixel (
    input  logic                bus_clk,
    input  logic                rst,
    input  pixel_pkg::bus_req_t bus,
    output pixel_pkg::byte_t    bus_rdata,
    input  logic                out_read,
    output logic                out_valid,
    output pixel_pkg::word_t    out_data,

    output logic sr_in,
    output logic global_sr_en,
    output logic global_ctr_ld,
    output logic global_dac_ld,
    output logic pixel_sr_en,
    output logic inject,
    input  logic pixel_sr_out,
    input  logic hit_or,

    output logic en_va1,
    output logic en_va2,
    output logic en_vd1,
    output logic en_vd2,
    output logic led1,
    output logic led2,
    output logic led3,
    output logic led4,
    output logic led5
);

    pixel_pkg::byte_t gpio_rdata, seq_rdata, spi_rdata, tdc_rdata;
    pixel_pkg::byte_t io;
    pixel_pkg::seq_t seq;
    pixel_pkg::word_t spi_data, tdc_data, arb_data;
    logic spi_empty, tdc_empty;
    logic [1:0] arb_grant;
    logic arb_write;
    logic out_empty, out_full;

    // unselected blocks return zero
    assign bus_rdata = gpio_rdata | seq_rdata | spi_rdata | tdc_rdata;

    gpio #(.base(pixel_pkg::gpio_base)) i_gpio (
        .bus_clk(bus_clk), .rst(rst), .bus(bus), .rdata(gpio_rdata), .io(io)
    );

    assign {en_vd1, en_vd2, en_va2, en_va1} = io[3:0];
    assign {led5, led4, led3, led2} = io[7:4];

    seq_gen i_seq_gen (
        .bus_clk(bus_clk), .rst(rst), .bus(bus), .rdata(seq_rdata), .seq_out(seq)
    );

    assign sr_in = seq.sr_in;
    assign global_sr_en = seq.global_sr_en;
    assign global_ctr_ld = seq.global_ctr_ld;
    assign global_dac_ld = seq.global_dac_ld;
    assign pixel_sr_en = seq.pixel_sr_en;
    assign inject = seq.inject;

    spi_rx i_spi_rx (
        .bus_clk(bus_clk), .rst(rst), .bus(bus), .rdata(spi_rdata),
        .sen(seq.pixel_sr_en), .sdi(pixel_sr_out),
        .pop(arb_grant[1]), .empty(spi_empty), .data(spi_data)
    );

    tdc i_tdc (
        .bus_clk(bus_clk), .rst(rst), .bus(bus), .rdata(tdc_rdata), .hit(hit_or),
        .pop(arb_grant[0]), .empty(tdc_empty), .data(tdc_data)
    );

    // serial receiver on request 1, hit timer on request 0
    rr_arbiter i_arbiter (
        .bus_clk(bus_clk), .rst(rst),
        .req({!spi_empty, !tdc_empty}), .data_in({spi_data, tdc_data}),
        .grant(arb_grant), .ready(!out_full), .write(arb_write), .data_out(arb_data)
    );

    sync_fifo #(
        .payload_t (pixel_pkg::word_t),
        .depth     (pixel_pkg::out_fifo_depth),
        .near_level(pixel_pkg::near_full_level)
    ) i_out_fifo (
        .bus_clk(bus_clk), .rst(rst), .push(arb_write), .push_data(arb_data),
        .pop(out_read), .data(out_data), .empty(out_empty), .full(out_full),
        .near_full(led1)
    );

    assign out_valid = !out_empty;

endmodule

/* tests/pixel_tb.sv */
// Testbench for the pixel readout controller, reference models, bus stimulus and output checks
module pixel_tb;

    timeunit 1ns;
    timeprecision 1ps;

    logic                bus_clk = 1'b0;
    logic                rst;
    pixel_pkg::bus_req_t bus;
    pixel_pkg::byte_t    bus_rdata;
    logic                out_read = 1'b0;
    logic                out_valid;
    pixel_pkg::word_t    out_data;
    logic sr_in, global_sr_en, global_ctr_ld, global_dac_ld, pixel_sr_en, inject;
    logic pixel_sr_out = 1'b0;
    logic hit_or;
    logic en_va1, en_va2, en_vd1, en_vd2, led1, led2, led3, led4, led5;

    int checks = 0;
    int errors = 0;
    bit stall = 1'b0;

    // model state
    bit spi_en_m = 1'b0;
    bit tdc_en_m = 1'b0;
    logic [11:0] spi_idx_m = '0;
    logic [11:0] tdc_idx_m = '0;
    int spi_cnt = 0;
    int spi_seen = 0;
    int hit_len = 0;
    logic spi_smp [16];
    pixel_pkg::word_t spi_exp[$];
    pixel_pkg::word_t tdc_exp[$];
    pixel_pkg::byte_t pattern [pixel_pkg::seq_mem_bytes];

    pixel dut (
        .bus_clk(bus_clk), .rst(rst), .bus(bus), .bus_rdata(bus_rdata),
        .out_read(out_read), .out_valid(out_valid), .out_data(out_data),
        .sr_in(sr_in), .global_sr_en(global_sr_en), .global_ctr_ld(global_ctr_ld),
        .global_dac_ld(global_dac_ld), .pixel_sr_en(pixel_sr_en), .inject(inject),
        .pixel_sr_out(pixel_sr_out), .hit_or(hit_or),
        .en_va1(en_va1), .en_va2(en_va2), .en_vd1(en_vd1), .en_vd2(en_vd2),
        .led1(led1), .led2(led2), .led3(led3), .led4(led4), .led5(led5)
    );

    always #5 bus_clk = ~bus_clk;

    // serial data toggles freely, only the sampled edges matter
    always @(posedge bus_clk) begin
        pixel_sr_out <= 1'($urandom);
    end

    // msb first, index from the enable write
    function automatic pixel_pkg::word_t spi_ref(input logic [11:0] idx, input logic smp [16]);
        pixel_pkg::word_t w;
        w.id = pixel_pkg::spi_rx_id;
        w.index = idx;
        for (int k = 0; k < 16; k++) begin
            w.payload[15 - k] = smp[k];
        end
        return w;
    endfunction

    function automatic pixel_pkg::word_t tdc_ref(input logic [11:0] idx, input int cycles);
        pixel_pkg::word_t w;
        w.id = pixel_pkg::tdc_id;
        w.index = idx;
        w.payload = (cycles > 65535) ? 16'hffff : 16'(cycles);
        return w;
    endfunction

    // spare bits have no pins
    function automatic pixel_pkg::seq_t seq_ref(input pixel_pkg::byte_t b);
        pixel_pkg::seq_t s;
        s = pixel_pkg::seq_t'(b);
        s.spare = '0;
        return s;
    endfunction

    function automatic pixel_pkg::seq_t seq_pins();
        pixel_pkg::seq_t s;
        s = '0;
        s.sr_in = sr_in;
        s.global_sr_en = global_sr_en;
        s.global_ctr_ld = global_ctr_ld;
        s.global_dac_ld = global_dac_ld;
        s.pixel_sr_en = pixel_sr_en;
        s.inject = inject;
        return s;
    endfunction

    function automatic pixel_pkg::byte_t gpio_pins();
        return {led5, led4, led3, led2, en_vd1, en_vd2, en_va2, en_va1};
    endfunction

    task automatic check_byte(input string name, input pixel_pkg::byte_t got,
                              input pixel_pkg::byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input pixel_pkg::word_t got,
                              input pixel_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_seq(input string name, input pixel_pkg::seq_t got,
                             input pixel_pkg::seq_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input pixel_pkg::byte_t data);
        @(posedge bus_clk);
        bus <= '{addr: addr, wdata: data, rd: 1'b0, wr: 1'b1};
        @(posedge bus_clk);
        bus <= '0;
    endtask

    // rdata is valid the cycle after rd
    task automatic bus_read(input logic [15:0] addr, output pixel_pkg::byte_t data);
        @(posedge bus_clk);
        bus <= '{addr: addr, wdata: 8'h00, rd: 1'b1, wr: 1'b0};
        @(posedge bus_clk);
        bus <= '0;
        @(negedge bus_clk);
        data = bus_rdata;
    endtask

    task automatic load_pattern(input int n);
        for (int i = 0; i < n; i++) begin
            bus_write(pixel_pkg::seq_base + pixel_pkg::seq_mem_offset + 16'(i), pattern[i]);
        end
    endtask

    task automatic wait_done(input int limit);
        pixel_pkg::byte_t v;
        int tries;
        v = '0;
        tries = 0;
        while (v[0] !== 1'b1 && tries < limit) begin
            bus_read(pixel_pkg::seq_base + 16'(pixel_pkg::reg_done), v);
            tries++;
        end
        if (v[0] !== 1'b1) begin
            errors++;
            $display("sequence generator never reported done");
        end
    endtask

    task automatic play_pattern(input int n);
        load_pattern(n);
        bus_write(pixel_pkg::seq_base + 16'(pixel_pkg::reg_len), pixel_pkg::byte_t'(n));
        bus_write(pixel_pkg::seq_base, 8'h01);
        wait_done(n + 10);
    endtask

    task automatic hit_pulse(input int len, input int gap);
        @(posedge bus_clk);
        hit_or <= 1'b1;
        repeat (len) @(posedge bus_clk);
        hit_or <= 1'b0;
        repeat (gap) @(posedge bus_clk);
    endtask

    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        while ((spi_exp.size() != 0 || tdc_exp.size() != 0) && waited < limit) begin
            @(negedge bus_clk);
            waited++;
        end
        if (spi_exp.size() != 0 || tdc_exp.size() != 0) begin
            errors++;
            $display("%0d serial and %0d hit words never reached the output port",
                     spi_exp.size(), tdc_exp.size());
        end
        repeat (8) @(negedge bus_clk);
    endtask

    // sampled at negedge, the values the DUT sees at the next rising edge
    always @(negedge bus_clk) begin
        if (rst || !spi_en_m || !pixel_sr_en) begin
            spi_cnt = 0;
        end else begin
            spi_smp[spi_cnt] = pixel_sr_out;
            spi_cnt = spi_cnt + 1;
            if (spi_cnt == 16) begin
                spi_exp.push_back(spi_ref(spi_idx_m, spi_smp));
                spi_idx_m = spi_idx_m + 12'd1;
                spi_cnt = 0;
            end
        end
    end

    always @(negedge bus_clk) begin
        if (rst) begin
            hit_len = 0;
        end else if (hit_or) begin
            hit_len = hit_len + 1;
        end else begin
            if (hit_len > 0 && tdc_en_m) begin
                tdc_exp.push_back(tdc_ref(tdc_idx_m, hit_len));
                tdc_idx_m = tdc_idx_m + 12'd1;
            end
            hit_len = 0;
        end
    end

    task automatic match_output(input pixel_pkg::word_t got);
        if (got.id == pixel_pkg::spi_rx_id && spi_exp.size() != 0) begin
            spi_seen++;
            check_word("out_data", got, spi_exp.pop_front());
        end else if (got.id == pixel_pkg::tdc_id && tdc_exp.size() != 0) begin
            check_word("out_data", got, tdc_exp.pop_front());
        end else begin
            errors++;
            $display("unexpected word %h on the output port at %0t", got, $time);
        end
    endtask

    // one pop every other cycle, none while stalled
    initial begin : compare
        wait (rst == 1'b0);
        forever begin
            @(negedge bus_clk);
            if (out_valid === 1'b1 && !stall) begin
                match_output(out_data);
                @(posedge bus_clk);
                out_read <= 1'b1;
                @(posedge bus_clk);
                out_read <= 1'b0;
            end
        end
    end

    task automatic finish_run();
        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    endtask

    initial begin : watchdog
        int limit;
        // gpio, playback, serial, hits with the saturating pulse, merge, margin
        limit = 100 + 1500 + 1000 + 67000 + 4000 + 5000;
        repeat (limit) @(posedge bus_clk);
        errors++;
        $display("watchdog expired after %0d cycles, the tests did not complete", limit);
        finish_run();
    end

    task automatic reset_and_gpio();
        pixel_pkg::byte_t g;
        pixel_pkg::byte_t v;
        @(negedge bus_clk);
        check_byte("gpio pins", gpio_pins(), 8'h00);
        check_byte("led1", {7'b0, led1}, 8'h00);
        check_byte("out_valid", {7'b0, out_valid}, 8'h00);
        check_seq("seq_out", seq_pins(), '0);
        bus_read(pixel_pkg::seq_base + 16'(pixel_pkg::reg_done), v);
        check_byte("seq done", v, 8'h00);
        bus_read(pixel_pkg::spi_rx_base, v);
        check_byte("spi_rx enable", v, 8'h00);
        bus_read(pixel_pkg::tdc_base, v);
        check_byte("tdc enable", v, 8'h00);
        bus_read(pixel_pkg::spi_rx_base + 16'(pixel_pkg::reg_lost), v);
        check_byte("spi_rx lost", v, 8'h00);
        bus_read(pixel_pkg::tdc_base + 16'(pixel_pkg::reg_lost), v);
        check_byte("tdc lost", v, 8'h00);
        g = pixel_pkg::byte_t'($urandom);
        bus_write(pixel_pkg::gpio_base, g);
        @(negedge bus_clk);
        check_byte("gpio pins", gpio_pins(), g);
        bus_read(pixel_pkg::gpio_base, v);
        check_byte("gpio readback", v, g);
    endtask

    task automatic sequence_playback();
        pixel_pkg::byte_t v;
        int n;
        n = 1 + int'($urandom % 255);
        for (int i = 0; i < n; i++) begin
            pattern[i] = pixel_pkg::byte_t'($urandom);
        end
        load_pattern(n);
        bus_write(pixel_pkg::seq_base + 16'(pixel_pkg::reg_len), pixel_pkg::byte_t'(n));
        bus_write(pixel_pkg::seq_base, 8'h01);
        // still idle in the cycle of the start write
        @(negedge bus_clk);
        check_seq("seq_out", seq_pins(), '0);
        for (int i = 0; i < n; i++) begin
            @(negedge bus_clk);
            check_seq("seq_out", seq_pins(), seq_ref(pattern[i]));
        end
        repeat (4) begin
            @(negedge bus_clk);
            check_seq("seq_out", seq_pins(), '0);
        end
        bus_read(pixel_pkg::seq_base + 16'(pixel_pkg::reg_done), v);
        check_byte("seq done", v, 8'h01);
    endtask

    task automatic serial_capture();
        int runs [7];
        int n;
        pixel_pkg::seq_t s;
        // enable runs of 32, 48 and 16 bits, then a partial group of 9
        runs = '{32, 4, 48, 3, 16, 2, 9};
        bus_write(pixel_pkg::spi_rx_base, 8'h01);
        spi_en_m = 1'b1;
        spi_idx_m = '0;
        spi_seen = 0;
        n = 0;
        for (int r = 0; r < 7; r++) begin
            for (int k = 0; k < runs[r]; k++) begin
                s = pixel_pkg::seq_t'($urandom);
                s.pixel_sr_en = (r % 2 == 0);
                pattern[n] = pixel_pkg::byte_t'(s);
                n++;
            end
        end
        play_pattern(n);
        wait_drain(500);
        // six full groups of 16 reach the output port
        check_byte("serial words", pixel_pkg::byte_t'(spi_seen), 8'd6);
    endtask

    task automatic hit_timing();
        bus_write(pixel_pkg::tdc_base, 8'h01);
        tdc_en_m = 1'b1;
        tdc_idx_m = '0;
        repeat (10) begin
            hit_pulse(1 + int'($urandom % 40), 2 + int'($urandom % 8));
        end
        wait_drain(500);
        // one pulse past the counter limit
        hit_pulse(65540, 4);
        wait_drain(500);
    endtask

    task automatic merge_backpressure();
        int plen [20];
        int pgap [20];
        int waited;
        pixel_pkg::byte_t v;
        for (int i = 0; i < 20; i++) begin
            plen[i] = 3 + int'($urandom % 10);
            pgap[i] = 3 + int'($urandom % 4);
        end
        stall = 1'b1;
        fork
            begin
                // 15 then 5 serial words
                for (int i = 0; i < 240; i++) begin
                    pattern[i] = pixel_pkg::byte_t'($urandom) | 8'h10;
                end
                play_pattern(240);
                for (int i = 0; i < 80; i++) begin
                    pattern[i] = pixel_pkg::byte_t'($urandom) | 8'h10;
                end
                play_pattern(80);
            end
            begin
                for (int i = 0; i < 20; i++) begin
                    hit_pulse(plen[i], pgap[i]);
                end
            end
        join
        waited = 0;
        while (led1 !== 1'b1 && waited < 100) begin
            @(negedge bus_clk);
            waited++;
        end
        if (led1 !== 1'b1) begin
            errors++;
            $display("led1 did not rise while the output port was not read");
        end
        stall = 1'b0;
        wait_drain(2000);
        check_byte("out_valid", {7'b0, out_valid}, 8'h00);
        check_byte("led1", {7'b0, led1}, 8'h00);
        bus_read(pixel_pkg::spi_rx_base + 16'(pixel_pkg::reg_lost), v);
        check_byte("spi_rx lost", v, 8'h00);
        bus_read(pixel_pkg::tdc_base + 16'(pixel_pkg::reg_lost), v);
        check_byte("tdc lost", v, 8'h00);
    endtask

    initial begin : stimulus
        void'($urandom(32'h9830_6109));
        rst = 1'b1;
        bus = '0;
        hit_or = 1'b0;
        repeat (8) @(posedge bus_clk);
        rst <= 1'b0;
        reset_and_gpio();
        sequence_playback();
        serial_capture();
        hit_timing();
        merge_backpressure();
        finish_run();
    end

endmodule

/* all.f */
hdl/pixel_pkg.sv
hdl/sync_fifo.sv
hdl/gpio.sv
hdl/seq_gen.sv
hdl/spi_rx.sv
hdl/tdc.sv
hdl/rr_arbiter.sv
hdl/pixel.sv
tests/pixel_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= pixel_tb
FILELIST ?= all.f
OBJ_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing -j 0

SOURCES := $(shell cat $(FILELIST))
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "Result: FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi
	@grep -q "Result: PASSED" $(LOG) || (echo "no pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
